// ==== rtl/csrDefsPkg.sv ====
`default_nettype none

package csrDefsPkg;

    localparam int timerWidth = 20;
    localparam int crmdWidth = 9;

    typedef logic [31:0] csrData_t;
    typedef logic [13:0] csrNum_t;
    typedef logic [5:0] ecode_t;
    typedef logic [8:0] esubcode_t;
    typedef logic [timerWidth-1:0] timerVal_t;

    // implemented csr numbers
    localparam csrNum_t CSR_CRMD = 14'h000;
    localparam csrNum_t CSR_PRMD = 14'h001;
    localparam csrNum_t CSR_EUEN = 14'h002;
    localparam csrNum_t CSR_ECFG = 14'h004;
    localparam csrNum_t CSR_ESTAT = 14'h005;
    localparam csrNum_t CSR_ERA = 14'h006;
    localparam csrNum_t CSR_BADV = 14'h007;
    localparam csrNum_t CSR_EENTRY = 14'h00c;
    localparam csrNum_t CSR_CPUID = 14'h020;
    localparam csrNum_t CSR_SAVE0 = 14'h030;
    localparam csrNum_t CSR_SAVE1 = 14'h031;
    localparam csrNum_t CSR_SAVE2 = 14'h032;
    localparam csrNum_t CSR_SAVE3 = 14'h033;
    localparam csrNum_t CSR_TID = 14'h040;
    localparam csrNum_t CSR_TCFG = 14'h041;
    localparam csrNum_t CSR_TVAL = 14'h042;
    localparam csrNum_t CSR_TICLR = 14'h044;
    localparam csrNum_t CSR_LLBCTL = 14'h060;
    localparam csrNum_t CSR_TLBRENTRY = 14'h088;

    // exception codes the hardware acts on
    localparam ecode_t ECODE_INT = 6'h00;
    localparam ecode_t ECODE_ADE = 6'h08;
    localparam ecode_t ECODE_TLBR = 6'h3f;
    localparam esubcode_t ESUB_ADEF = 9'h000;

    // DA=1, PG=0, IE=0, PLV=0
    localparam logic [crmdWidth-1:0] crmdResetVal = 9'd8;

endpackage

`default_nettype wire

// ==== rtl/pipeDefsPkg.sv ====
`default_nettype none

package pipeDefsPkg;

    typedef logic [3:0] instType_t;
    typedef logic [4:0] instSubtype_t;

    localparam instType_t TYPE_PRIV = 4'd3;
    localparam instType_t TYPE_LLW = 4'd6;

    localparam instSubtype_t SUB_LOAD = 5'd0;
    localparam instSubtype_t SUB_ERTN = 5'd6;
    localparam instSubtype_t SUB_IDLE = 5'd7;
    localparam instSubtype_t SUB_CSRRD = 5'd8;
    localparam instSubtype_t SUB_CSRWR = 5'd9;
    localparam instSubtype_t SUB_CSRXCHG = 5'd10;

    // idleWait keeps the core clock stopped
    typedef enum logic {
        run,
        idleWait
    } ctrlState_e;

endpackage

`default_nettype wire

// ==== rtl/csrAccessIf.sv ====
`timescale 1ns/100ps
`default_nettype none

interface csrAccessIf;

    import csrDefsPkg::*;

    logic wrEn;
    csrNum_t num;
    csrData_t wdata;
    csrData_t wmask;
    // combinational from num
    csrData_t rdata;

    modport ctrl (
        output wrEn, num, wdata, wmask,
        input rdata
    );

    modport regs (
        input wrEn, num, wdata, wmask,
        output rdata
    );

endinterface

`default_nettype wire

// ==== rtl/csrTrapIf.sv ====
`timescale 1ns/100ps
`default_nettype none

interface csrTrapIf;

    import csrDefsPkg::*;

    // one cycle pulses
    logic trapTake;
    logic ertnTake;
    logic llSet;
    logic trapTlbr;
    ecode_t trapEcode;
    esubcode_t trapEsubcode;
    csrData_t trapEra;
    csrData_t trapBadv;

    logic crmdIe;
    // ESTAT.IS masked by ECFG.LIE, reserved bit 10 removed
    logic [11:0] intPending;
    csrData_t eentry;
    csrData_t tlbrentry;
    csrData_t era;
    ecode_t estatEcode;

    modport ctrl (
        output trapTake, trapTlbr, ertnTake, llSet, trapEcode, trapEsubcode, trapEra, trapBadv,
        input crmdIe, intPending, eentry, tlbrentry, era, estatEcode
    );

    modport regs (
        input trapTake, trapTlbr, ertnTake, llSet, trapEcode, trapEsubcode, trapEra, trapBadv,
        output crmdIe, intPending, eentry, tlbrentry, era, estatEcode
    );

endinterface

`default_nettype wire

// ==== rtl/csrTrapCtrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module csrTrapCtrl (
    input wire logic clk,
    input wire logic rstn,
    input wire logic pipeStall,
    input wire logic pipeFlush,
    input wire pipeDefsPkg::instType_t instType,
    input wire pipeDefsPkg::instSubtype_t instSubtype,
    input wire logic excpValid,
    input wire logic [15:0] excpArg,
    input wire csrDefsPkg::csrData_t inPc,
    input wire csrDefsPkg::csrData_t badVaddr,
    input wire csrDefsPkg::csrData_t wdata,
    input wire csrDefsPkg::csrData_t wmask,
    output logic csrFlush,
    output csrDefsPkg::csrData_t outPc,
    output logic clkStall,
    csrAccessIf.ctrl acc,
    csrTrapIf.ctrl trap
);

    import csrDefsPkg::*;
    import pipeDefsPkg::*;

    ctrlState_e state;
    logic intTake;
    logic accept;
    logic take;
    logic ertn;
    logic idleGo;
    ecode_t ecode;
    esubcode_t esubcode;

    always_comb
    begin
        intTake = trap.crmdIe && (|trap.intPending) && !pipeFlush;
        accept = !pipeStall && !pipeFlush
            && (instType == TYPE_PRIV || (instType == TYPE_LLW && instSubtype == SUB_LOAD)
                || excpValid);
        ecode = excpArg[5:0];
        esubcode = excpArg[14:6];
        take = 1'b0;
        ertn = 1'b0;
        idleGo = 1'b0;
        trap.llSet = 1'b0;
        acc.wrEn = 1'b0;
        acc.wmask = '1;

        // interrupt beats exception beats instruction
        if (intTake)
        begin
            take = 1'b1;
            ecode = ECODE_INT;
            esubcode = '0;
        end
        else if (accept && excpValid)
        begin
            take = 1'b1;
        end
        else if (accept && instType == TYPE_PRIV)
        begin
            case (instSubtype)
                SUB_ERTN: ertn = 1'b1;
                SUB_IDLE: idleGo = 1'b1;
                SUB_CSRRD: acc.wrEn = 1'b0;
                SUB_CSRWR: acc.wrEn = 1'b1;
                SUB_CSRXCHG:
                begin
                    acc.wrEn = 1'b1;
                    acc.wmask = wmask;
                end
                default: acc.wrEn = 1'b0;
            endcase
        end
        else if (accept)
        begin
            // only ll.w remains here
            trap.llSet = 1'b1;
        end
    end

    assign acc.num = excpArg[13:0];
    assign acc.wdata = wdata;

    assign trap.trapTake = take;
    assign trap.ertnTake = ertn;
    assign trap.trapTlbr = take && ecode == ECODE_TLBR;
    assign trap.trapEcode = ecode;
    assign trap.trapEsubcode = esubcode;
    assign trap.trapEra = inPc;
    // fetch address errors report the pc itself
    assign trap.trapBadv = (ecode == ECODE_ADE && esubcode == ESUB_ADEF) ? inPc : badVaddr;

    assign csrFlush = take || ertn;

    always_comb
    begin
        if (ertn)
            outPc = trap.era;
        else if (take && ecode == ECODE_TLBR)
            outPc = trap.tlbrentry;
        else
            outPc = trap.eentry;
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
            state <= run;
        else
        begin
            case (state)
                run:
                    if (idleGo)
                        state <= idleWait;
                idleWait:
                    if (intTake)
                        state <= run;
                default: state <= run;
            endcase
        end
    end

    assign clkStall = state == idleWait;

endmodule

`default_nettype wire

// ==== rtl/csrRegFile.sv ====
`timescale 1ns/100ps
`default_nettype none

module csrRegFile (
    input wire logic clk,
    input wire logic rstn,
    input wire logic [7:0] hwInt,
    input wire logic ipi,
    input wire logic timerInt,
    input wire csrDefsPkg::timerVal_t tval,
    output logic tcfgLoad,
    output logic tcfgEn,
    output logic tcfgPeriodic,
    output csrDefsPkg::timerVal_t tcfgInit,
    output logic ticlrWrite,
    csrAccessIf.regs acc,
    csrTrapIf.regs trap
);

    import csrDefsPkg::*;

    logic [crmdWidth-1:0] crmd;
    logic [2:0] prmd;
    logic euen;
    // LIE bits 12:11 and 9:0
    logic [11:0] ecfgLie;
    logic [1:0] estatIs;
    ecode_t estatEcode;
    esubcode_t estatEsubcode;
    csrData_t era;
    csrData_t badv;
    logic [25:0] eentry;
    logic [25:0] tlbrentry;
    csrData_t save [4];
    csrData_t tid;
    timerVal_t tcfg;
    timerVal_t tcfgNext;
    logic llbRollb;
    logic llbKlo;
    csrData_t wrMerge;

    always_comb
    begin
        case (acc.num)
            CSR_CRMD: acc.rdata = csrData_t'(crmd);
            CSR_PRMD: acc.rdata = csrData_t'(prmd);
            CSR_EUEN: acc.rdata = csrData_t'(euen);
            CSR_ECFG: acc.rdata = {19'b0, ecfgLie[11:10], 1'b0, ecfgLie[9:0]};
            CSR_ESTAT:
                acc.rdata = {1'b0, estatEsubcode, estatEcode, 3'b0, ipi, timerInt, 1'b0,
                    hwInt, estatIs};
            CSR_ERA: acc.rdata = era;
            CSR_BADV: acc.rdata = badv;
            CSR_EENTRY: acc.rdata = {eentry, 6'b0};
            CSR_CPUID: acc.rdata = '0;
            CSR_SAVE0: acc.rdata = save[0];
            CSR_SAVE1: acc.rdata = save[1];
            CSR_SAVE2: acc.rdata = save[2];
            CSR_SAVE3: acc.rdata = save[3];
            CSR_TID: acc.rdata = tid;
            CSR_TCFG: acc.rdata = csrData_t'(tcfg);
            CSR_TVAL: acc.rdata = csrData_t'(tval);
            CSR_TICLR: acc.rdata = '0;
            // WCLLB always reads zero
            CSR_LLBCTL: acc.rdata = {29'b0, llbKlo, 1'b0, llbRollb};
            CSR_TLBRENTRY: acc.rdata = {tlbrentry, 6'b0};
            default: acc.rdata = '0;
        endcase
    end

    assign wrMerge = (acc.rdata & ~acc.wmask) | (acc.wdata & acc.wmask);

    // timer sees the value being written in the load cycle
    assign tcfgLoad = acc.wrEn && acc.num == CSR_TCFG;
    assign tcfgNext = tcfgLoad ? wrMerge[timerWidth-1:0] : tcfg;
    assign tcfgEn = tcfgNext[0];
    assign tcfgPeriodic = tcfgNext[1];
    assign tcfgInit = {tcfgNext[timerWidth-1:2], 2'b00};
    assign ticlrWrite = acc.wrEn && acc.num == CSR_TICLR && wrMerge[0];

    assign trap.crmdIe = crmd[2];
    assign trap.intPending = {ipi, timerInt, hwInt, estatIs} & ecfgLie;
    assign trap.eentry = {eentry, 6'b0};
    assign trap.tlbrentry = {tlbrentry, 6'b0};
    assign trap.era = era;
    assign trap.estatEcode = estatEcode;

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd <= crmdResetVal;
            prmd <= '0;
            euen <= 1'b0;
            ecfgLie <= '0;
            estatIs <= '0;
            estatEcode <= '0;
            estatEsubcode <= '0;
            tcfg <= '0;
            llbRollb <= 1'b0;
            llbKlo <= 1'b0;
        end
        else if (trap.trapTake)
        begin
            prmd <= crmd[2:0];
            crmd[2:0] <= 3'b000;
            if (trap.trapTlbr)
                crmd[4:3] <= 2'b01;
            estatEcode <= trap.trapEcode;
            estatEsubcode <= trap.trapEsubcode;
        end
        else if (trap.ertnTake)
        begin
            crmd[2:0] <= prmd;
            // leaving the refill handler turns paging back on
            if (trap.estatEcode == ECODE_TLBR)
                crmd[4:3] <= 2'b10;
            llbKlo <= 1'b0;
            if (!llbKlo)
                llbRollb <= 1'b0;
        end
        else if (trap.llSet)
            llbRollb <= 1'b1;
        else if (acc.wrEn)
        begin
            case (acc.num)
                CSR_CRMD:
                begin
                    crmd[2:0] <= wrMerge[2:0];
                    crmd[8:5] <= wrMerge[8:5];
                    if (wrMerge[4] ^ wrMerge[3])
                        crmd[4:3] <= wrMerge[4:3];
                end
                CSR_PRMD: prmd <= wrMerge[2:0];
                CSR_EUEN: euen <= wrMerge[0];
                CSR_ECFG: ecfgLie <= {wrMerge[12:11], wrMerge[9:0]};
                CSR_ESTAT: estatIs <= wrMerge[1:0];
                CSR_TCFG: tcfg <= wrMerge[timerWidth-1:0];
                CSR_LLBCTL:
                begin
                    if (wrMerge[1])
                        llbRollb <= 1'b0;
                    llbKlo <= wrMerge[2];
                end
                default: ;
            endcase
        end
    end

    // data registers
    always_ff @(posedge clk)
    begin
        if (trap.trapTake)
        begin
            era <= trap.trapEra;
            badv <= trap.trapBadv;
        end
        else if (acc.wrEn)
        begin
            case (acc.num)
                CSR_ERA: era <= wrMerge;
                CSR_BADV: badv <= wrMerge;
                CSR_EENTRY: eentry <= wrMerge[31:6];
                CSR_SAVE0: save[0] <= wrMerge;
                CSR_SAVE1: save[1] <= wrMerge;
                CSR_SAVE2: save[2] <= wrMerge;
                CSR_SAVE3: save[3] <= wrMerge;
                CSR_TID: tid <= wrMerge;
                CSR_TLBRENTRY: tlbrentry <= wrMerge[31:6];
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/csrTimer.sv ====
`timescale 1ns/100ps
`default_nettype none

module csrTimer (
    input wire logic clk,
    input wire logic rstn,
    input wire logic tcfgLoad,
    input wire logic tcfgEn,
    input wire logic tcfgPeriodic,
    input wire csrDefsPkg::timerVal_t tcfgInit,
    input wire logic ticlrWrite,
    output csrDefsPkg::timerVal_t tval,
    output logic timerInt
);

    import csrDefsPkg::*;

    logic running;
    logic expire;

    assign expire = running && !tcfgLoad && tval == '0;

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            running <= 1'b0;
            tval <= '0;
        end
        else if (tcfgLoad)
        begin
            running <= tcfgEn;
            if (tcfgEn)
                tval <= tcfgInit;
        end
        else if (expire)
        begin
            // one shot mode stops at zero
            if (tcfgPeriodic)
                tval <= tcfgInit;
            else
                running <= 1'b0;
        end
        else if (running)
            tval <= tval - timerVal_t'(1);
    end

    // clear wins over a same-edge expiry
    always_ff @(posedge clk)
    begin
        if (!rstn)
            timerInt <= 1'b0;
        else if (ticlrWrite)
            timerInt <= 1'b0;
        else if (expire)
            timerInt <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== rtl/csrUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module csrUnit (
    input wire logic clk,
    input wire logic rstn,
    input wire logic pipeStall,
    input wire logic pipeFlush,
    input wire pipeDefsPkg::instType_t instType,
    input wire pipeDefsPkg::instSubtype_t instSubtype,
    input wire logic excpValid,
    input wire logic [15:0] excpArg,
    input wire csrDefsPkg::csrData_t inPc,
    input wire csrDefsPkg::csrData_t badVaddr,
    input wire csrDefsPkg::csrData_t wdata,
    input wire csrDefsPkg::csrData_t wmask,
    input wire logic [7:0] hwInt,
    input wire logic ipi,
    output logic csrFlush,
    output csrDefsPkg::csrData_t outPc,
    output csrDefsPkg::csrData_t rdata,
    output logic clkStall
);

    import csrDefsPkg::*;

    csrAccessIf accIf ();
    csrTrapIf trapIf ();

    timerVal_t tval;
    timerVal_t tcfgInit;
    logic tcfgLoad;
    logic tcfgEn;
    logic tcfgPeriodic;
    logic ticlrWrite;
    logic timerInt;

    csrTrapCtrl uCtrl (
        .clk(clk),
        .rstn(rstn),
        .pipeStall(pipeStall),
        .pipeFlush(pipeFlush),
        .instType(instType),
        .instSubtype(instSubtype),
        .excpValid(excpValid),
        .excpArg(excpArg),
        .inPc(inPc),
        .badVaddr(badVaddr),
        .wdata(wdata),
        .wmask(wmask),
        .csrFlush(csrFlush),
        .outPc(outPc),
        .clkStall(clkStall),
        .acc(accIf.ctrl),
        .trap(trapIf.ctrl)
    );

    csrRegFile uRegs (
        .clk(clk),
        .rstn(rstn),
        .hwInt(hwInt),
        .ipi(ipi),
        .timerInt(timerInt),
        .tval(tval),
        .tcfgLoad(tcfgLoad),
        .tcfgEn(tcfgEn),
        .tcfgPeriodic(tcfgPeriodic),
        .tcfgInit(tcfgInit),
        .ticlrWrite(ticlrWrite),
        .acc(accIf.regs),
        .trap(trapIf.regs)
    );

    csrTimer uTimer (
        .clk(clk),
        .rstn(rstn),
        .tcfgLoad(tcfgLoad),
        .tcfgEn(tcfgEn),
        .tcfgPeriodic(tcfgPeriodic),
        .tcfgInit(tcfgInit),
        .ticlrWrite(ticlrWrite),
        .tval(tval),
        .timerInt(timerInt)
    );

    assign rdata = accIf.rdata;

endmodule

`default_nettype wire

// ==== test/csrUnitTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module csrUnitTb;

    import csrDefsPkg::*;
    import pipeDefsPkg::*;

    localparam int clkPeriod = 40;
    localparam int tvalMax = 44;
    // timer runs dominate the op count
    localparam int opBudget = 100 + 3 * (tvalMax + 6);
    localparam csrData_t ones = '1;

    logic clk;
    logic rstn;
    logic pipeStall;
    logic pipeFlush;
    instType_t instType;
    instSubtype_t instSubtype;
    logic excpValid;
    logic [15:0] excpArg;
    csrData_t inPc;
    csrData_t badVaddr;
    csrData_t wdata;
    csrData_t wmask;
    logic [7:0] hwInt;
    logic ipi;
    logic csrFlush;
    csrData_t outPc;
    csrData_t rdata;
    logic clkStall;

    logic [31:0] lfsr = 32'h3646_9017;
    int edgeCnt = 0;
    logic hwLine;
    // shadow CSRs indexed by the low byte of the number
    csrData_t shadow [0:255];
    logic known [0:255];
    ecode_t ecodeM;
    esubcode_t esubM;
    logic [1:0] isM;
    logic tiM;

    csrUnit DUT (
        .clk(clk),
        .rstn(rstn),
        .pipeStall(pipeStall),
        .pipeFlush(pipeFlush),
        .instType(instType),
        .instSubtype(instSubtype),
        .excpValid(excpValid),
        .excpArg(excpArg),
        .inPc(inPc),
        .badVaddr(badVaddr),
        .wdata(wdata),
        .wmask(wmask),
        .hwInt(hwInt),
        .ipi(ipi),
        .csrFlush(csrFlush),
        .outPc(outPc),
        .rdata(rdata),
        .clkStall(clkStall)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk)
        edgeCnt <= edgeCnt + 1;

    task automatic stopOnError();
        $display("Result: FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    // nothing reaches the fetch while the pipeline flushes
    assert property (@(posedge clk) disable iff (!rstn) pipeFlush |-> !csrFlush)
    else
    begin
        $display("ERR csrFlush got %h expected %h under pipeFlush", $sampled(csrFlush), 1'b0);
        stopOnError();
    end

    // the clock restarts only through a taken interrupt
    assert property (@(posedge clk) disable iff (!rstn) $fell(clkStall) |-> $past(csrFlush))
    else
    begin
        $display("clkStall fell without a trap in the cycle before");
        stopOnError();
    end

    initial
    begin
        #(opBudget * 2 * clkPeriod);
        $display("timeout: no result after %0d cycles", opBudget * 2);
        stopOnError();
    end

    // galois lfsr, one step per bit taken
    function automatic csrData_t randWord(input int nBits);
        csrData_t r;
        r = '0;
        for (int i = 0; i < nBits; i++)
        begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic int slot(input csrNum_t num);
        return int'(num[7:0]);
    endfunction

    function automatic csrData_t writeMask(input csrNum_t num);
        case (num)
            CSR_CRMD: return 32'h0000_01ff;
            CSR_PRMD: return 32'h0000_0007;
            CSR_EUEN: return 32'h0000_0001;
            CSR_ECFG: return 32'h0000_1bff;
            CSR_EENTRY, CSR_TLBRENTRY: return 32'hffff_ffc0;
            CSR_ERA, CSR_BADV, CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID: return ones;
            CSR_TCFG: return 32'h000f_ffff;
            default: return '0;
        endcase
    endfunction

    function automatic csrData_t expectRead(input csrNum_t num);
        if (num == CSR_ESTAT)
            return {1'b0, esubM, ecodeM, 3'b0, ipi, tiM, 1'b0, hwInt, isM};
        return shadow[slot(num)];
    endfunction

    function automatic csrData_t tvalExpect(input int j, input int n, input logic periodic);
        if (periodic)
            return csrData_t'(n - j % (n + 1));
        return (j > n) ? '0 : csrData_t'(n - j);
    endfunction

    task automatic check(input string name, input csrData_t got, input csrData_t exp);
        assert (got === exp)
        else
        begin
            $display("ERR %s got %h expected %h", name, got, exp);
            stopOnError();
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        assert (got === exp)
        else
        begin
            $display("ERR %s got %h expected %h", name, got, exp);
            stopOnError();
        end
    endtask

    task automatic modelWrite(input csrNum_t num, input csrData_t wd, input csrData_t wm);
        csrData_t merged;
        merged = (expectRead(num) & ~wm) | (wd & wm);
        if (num == CSR_ESTAT)
            isM = merged[1:0];
        else if (num == CSR_CRMD && !(merged[4] ^ merged[3]))
            shadow[slot(num)] = {23'b0, merged[8:5], shadow[slot(num)][4:3], merged[2:0]};
        else
            shadow[slot(num)] = merged & writeMask(num);
        known[slot(num)] = 1'b1;
    endtask

    task automatic drive(input instType_t t, input instSubtype_t s, input logic [15:0] arg,
            input csrData_t wd, input csrData_t wm, input logic exc, input logic stall,
            input logic flush);
        @(negedge clk);
        instType = t;
        instSubtype = s;
        excpArg = arg;
        wdata = wd;
        wmask = wm;
        excpValid = exc;
        pipeStall = stall;
        pipeFlush = flush;
        hwInt = {7'b0, hwLine};
        inPc = randWord(30) << 2;
        badVaddr = randWord(32);
        // sample mid low phase, away from both edges
        #(clkPeriod / 4);
    endtask

    task automatic bubble();
        drive('0, '0, '0, '0, '0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic csrRead(input csrNum_t num);
        drive(TYPE_PRIV, SUB_CSRRD, {2'b0, num}, randWord(32), '0, 1'b0, 1'b0, 1'b0);
        checkBit("csrFlush", csrFlush, 1'b0);
        check($sformatf("rdata[%h]", num), rdata, expectRead(num));
    endtask

    task automatic csrAccess(input csrNum_t num, input csrData_t wd, input csrData_t wm,
            input logic xchg);
        drive(TYPE_PRIV, xchg ? SUB_CSRXCHG : SUB_CSRWR, {2'b0, num}, wd, wm, 1'b0, 1'b0,
            1'b0);
        checkBit("csrFlush", csrFlush, 1'b0);
        if (known[slot(num)])
            check($sformatf("rdata[%h]", num), rdata, expectRead(num));
        modelWrite(num, wd, xchg ? wm : ones);
    endtask

    task automatic csrWrite(input csrNum_t num, input csrData_t wd);
        csrAccess(num, wd, randWord(32), 1'b0);
    endtask

    task automatic expectTrap(input ecode_t ec, input esubcode_t es);
        checkBit("csrFlush", csrFlush, 1'b1);
        check("outPc", outPc,
            (ec == ECODE_TLBR) ? shadow[slot(CSR_TLBRENTRY)] : shadow[slot(CSR_EENTRY)]);
        shadow[slot(CSR_PRMD)] = {29'b0, shadow[slot(CSR_CRMD)][2:0]};
        shadow[slot(CSR_CRMD)][2:0] = 3'b000;
        if (ec == ECODE_TLBR)
            shadow[slot(CSR_CRMD)][4:3] = 2'b01;
        shadow[slot(CSR_ERA)] = inPc;
        shadow[slot(CSR_BADV)] = (ec == ECODE_ADE && es == ESUB_ADEF) ? inPc : badVaddr;
        known[slot(CSR_ERA)] = 1'b1;
        known[slot(CSR_BADV)] = 1'b1;
        ecodeM = ec;
        esubM = es;
    endtask

    task automatic returnFromTrap();
        drive(TYPE_PRIV, SUB_ERTN, '0, '0, '0, 1'b0, 1'b0, 1'b0);
        checkBit("csrFlush", csrFlush, 1'b1);
        check("outPc", outPc, shadow[slot(CSR_ERA)]);
        shadow[slot(CSR_CRMD)][2:0] = shadow[slot(CSR_PRMD)][2:0];
        if (ecodeM == ECODE_TLBR)
            shadow[slot(CSR_CRMD)][4:3] = 2'b10;
    endtask

    task automatic timerRun(input int n, input logic periodic, input int reads);
        int loadEdge;
        int j;
        logic readStat;
        csrWrite(CSR_TCFG, csrData_t'(n) | (periodic ? 32'h3 : 32'h1));
        loadEdge = edgeCnt + 1;
        for (int i = 0; i < reads; i++)
        begin
            // ESTAT on odd reads and on the last count before expiry
            readStat = (i % 2 == 1) || i == n;
            drive(TYPE_PRIV, SUB_CSRRD, {2'b0, readStat ? CSR_ESTAT : CSR_TVAL}, '0, '0,
                1'b0, 1'b0, 1'b0);
            j = edgeCnt - loadEdge;
            // TI shows once the edge after zero has passed
            tiM = j > n;
            if (readStat)
                check("rdata[ESTAT]", rdata, expectRead(CSR_ESTAT));
            else
                check("rdata[TVAL]", rdata, tvalExpect(j, n, periodic));
        end
    endtask

    initial
    begin
        csrNum_t plain [6];
        ecode_t ec;
        esubcode_t es;
        csrNum_t num;
        int n;
        plain = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_ERA, CSR_EENTRY};
        rstn = 1'b0;
        pipeStall = 1'b0;
        pipeFlush = 1'b0;
        instType = '0;
        instSubtype = '0;
        excpValid = 1'b0;
        excpArg = '0;
        inPc = '0;
        badVaddr = '0;
        wdata = '0;
        wmask = '0;
        hwInt = '0;
        ipi = 1'b0;
        hwLine = 1'b0;
        ecodeM = '0;
        esubM = '0;
        isM = '0;
        tiM = 1'b0;
        for (int i = 0; i < 256; i++)
        begin
            shadow[i] = '0;
            known[i] = 1'b0;
        end
        shadow[slot(CSR_CRMD)] = 32'(crmdResetVal);
        known[slot(CSR_CRMD)] = 1'b1;
        known[slot(CSR_PRMD)] = 1'b1;
        known[slot(CSR_ECFG)] = 1'b1;
        known[slot(CSR_ESTAT)] = 1'b1;
        known[slot(CSR_TCFG)] = 1'b1;
        known[slot(CSR_TICLR)] = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        // reset values and plain accesses
        csrRead(CSR_CRMD);
        checkBit("clkStall", clkStall, 1'b0);
        for (int k = 0; k < 6; k++)
        begin
            csrWrite(plain[k], randWord(32));
            csrWrite(plain[k], randWord(32));
            csrRead(plain[k]);
        end

        // masked exchange
        for (int k = 0; k < 8; k++)
        begin
            num = (k % 2) ? CSR_ECFG : plain[k / 2];
            csrAccess(num, randWord(32), randWord(32), 1'b1);
            csrRead(num);
        end

        // exceptions and return
        csrWrite(CSR_TLBRENTRY, randWord(32));
        csrWrite(CSR_ECFG, '0);
        csrWrite(CSR_CRMD, 32'h0000_0017);
        for (int k = 0; k < 3; k++)
        begin
            ec = (k == 0) ? ecode_t'(randWord(5) + 1) : (k == 1) ? ECODE_ADE : ECODE_TLBR;
            es = (k == 1) ? ESUB_ADEF : esubcode_t'(randWord(9));
            drive('0, '0, {1'b0, es, ec}, '0, '0, 1'b1, 1'b0, 1'b0);
            expectTrap(ec, es);
            csrRead(CSR_ERA);
            csrRead(CSR_ESTAT);
            csrRead(CSR_BADV);
            csrRead(CSR_PRMD);
            csrRead(CSR_CRMD);
            returnFromTrap();
            csrRead(CSR_CRMD);
        end

        // software interrupt, blocked by pipeFlush first
        csrWrite(CSR_ECFG, 32'h1);
        csrWrite(CSR_ESTAT, 32'h1);
        drive('0, '0, '0, '0, '0, 1'b0, 1'b0, 1'b1);
        checkBit("csrFlush", csrFlush, 1'b0);
        drive(TYPE_PRIV, SUB_CSRWR, {2'b0, CSR_SAVE0}, randWord(32), ones, 1'b0, 1'b0, 1'b0);
        expectTrap(ECODE_INT, '0);
        csrRead(CSR_SAVE0);
        csrRead(CSR_ESTAT);
        csrRead(CSR_PRMD);
        csrWrite(CSR_ESTAT, '0);
        csrWrite(CSR_ECFG, 32'h4);
        returnFromTrap();

        // hardware line 0
        hwLine = 1'b1;
        drive(TYPE_PRIV, SUB_CSRRD, {2'b0, CSR_CRMD}, '0, '0, 1'b0, 1'b0, 1'b0);
        expectTrap(ECODE_INT, '0);
        hwLine = 1'b0;
        csrRead(CSR_ESTAT);
        csrRead(CSR_CRMD);

        // timer, one shot then periodic
        n = 16 + 4 * int'(randWord(3));
        timerRun(n, 1'b0, n + 6);
        csrWrite(CSR_TICLR, 32'h1);
        tiM = 1'b0;
        csrRead(CSR_ESTAT);
        timerRun(n, 1'b1, 2 * (n + 1) + 2);
        csrWrite(CSR_TICLR, 32'h1);
        tiM = 1'b0;
        csrRead(CSR_ESTAT);
        csrWrite(CSR_TCFG, '0);
        csrRead(CSR_TCFG);

        // idle until an enabled interrupt
        csrWrite(CSR_CRMD, 32'h0000_001c);
        drive(TYPE_PRIV, SUB_IDLE, '0, '0, '0, 1'b0, 1'b1, 1'b0);
        bubble();
        checkBit("clkStall", clkStall, 1'b0);
        drive(TYPE_PRIV, SUB_IDLE, '0, '0, '0, 1'b0, 1'b0, 1'b0);
        checkBit("clkStall", clkStall, 1'b0);
        repeat (3)
        begin
            bubble();
            checkBit("clkStall", clkStall, 1'b1);
            checkBit("csrFlush", csrFlush, 1'b0);
        end
        hwLine = 1'b1;
        bubble();
        checkBit("clkStall", clkStall, 1'b1);
        expectTrap(ECODE_INT, '0);
        hwLine = 1'b0;
        bubble();
        checkBit("clkStall", clkStall, 1'b0);
        checkBit("csrFlush", csrFlush, 1'b0);
        csrRead(CSR_CRMD);

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== csrUnit.f ====
rtl/csrDefsPkg.sv
rtl/pipeDefsPkg.sv
rtl/csrAccessIf.sv
rtl/csrTrapIf.sv
rtl/csrTrapCtrl.sv
rtl/csrRegFile.sv
rtl/csrTimer.sv
rtl/csrUnit.sv
test/csrUnitTb.sv

// ==== Bender.yml ====
package:
  name: csrUnit

sources:
  - rtl/csrDefsPkg.sv
  - rtl/pipeDefsPkg.sv
  - rtl/csrAccessIf.sv
  - rtl/csrTrapIf.sv
  - rtl/csrTrapCtrl.sv
  - rtl/csrRegFile.sv
  - rtl/csrTimer.sv
  - rtl/csrUnit.sv
  - target: test
    files:
      - test/csrUnitTb.sv
